// ==== src/inv_column_pkg.sv ====
package inv_column_pkg;

    typedef logic [7:0] byte_t;

    // row 0 of the column sits in the most significant byte
    typedef byte_t [3:0] column_t;

    typedef enum logic [1:0] {
        OP_INV_SUB_WORD   = 2'd1,
        OP_INV_MIX_COLUMN = 2'd2
    } op_t;

    typedef struct packed {
        logic    valid;
        column_t data;
    } col_req_t;

    typedef struct packed {
        logic    valid;
        column_t data;
    } col_rsp_t;

    typedef logic [3:0] apb_addr_t;

    localparam apb_addr_t REG_CTRL   = 4'd0;
    localparam apb_addr_t REG_DATA   = 4'd4;
    localparam apb_addr_t REG_RESULT = 4'd8;
    localparam apb_addr_t REG_STATUS = 4'd12;

    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // inverse S-box, one row of sixteen entries per line, entry 0 leftmost
    localparam byte_t [0:255] INV_SBOX = {
        128'h52096ad5_3036a538_bf40a39e_81f3d7fb,
        128'h7ce33982_9b2fff87_348e4344_c4dee9cb,
        128'h547b9432_a6c2233d_ee4c950b_42fac34e,
        128'h082ea166_28d924b2_765ba249_6d8bd125,
        128'h72f8f664_86689816_d4a45ccc_5d65b692,
        128'h6c704850_fdedb9da_5e154657_a78d9d84,
        128'h90d8ab00_8cbcd30a_f7e45805_b8b34506,
        128'hd02c1e8f_ca3f0f02_c1afbd03_01138a6b,
        128'h3a911141_4f67dcea_97f2cfce_f0b4e673,
        128'h96ac7422_e7ad3585_e2f937e8_1c75df6e,
        128'h47f11a71_1d29c589_6fb7620e_aa18be1b,
        128'hfc563e4b_c6d27920_9adbc0fe_78cd5af4,
        128'h1fdda833_8807c731_b1121059_2780ec5f,
        128'h60517fa9_19b54a0d_2de57a9f_93c99cef,
        128'ha0e03b4d_ae2af5b0_c8ebbb3c_83539961,
        128'h172b047e_ba77d626_e1691463_55210c7d
    };

    // multiply by 02 in GF(2^8), folding the carry back with the AES polynomial
    function automatic byte_t xtime(byte_t b);
        byte_t shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7]) begin
            return shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

endpackage

// ==== src/inv_column_apb.sv ====
module inv_column_apb (
    input  logic                      clk,
    input  logic                      arst_n,
    input  inv_column_pkg::apb_addr_t paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output inv_column_pkg::col_req_t  sub_req,
    output inv_column_pkg::col_req_t  mix_req,
    input  inv_column_pkg::col_rsp_t  sub_rsp,
    input  inv_column_pkg::col_rsp_t  mix_rsp
);

    logic                    access;
    logic                    op_ok;
    logic                    start;
    logic                    data_wr;
    logic                    rsp_valid;
    logic [31:0]             status;
    inv_column_pkg::op_t     op;
    inv_column_pkg::column_t data_q;
    inv_column_pkg::column_t result_q;
    logic                    busy_q;
    logic                    done_q;
    logic                    sub_valid_q;
    logic                    mix_valid_q;

    assign access = psel && penable;
    assign pready = 1'b1;

    assign op    = inv_column_pkg::op_t'(pwdata[1:0]);
    assign op_ok = (op == inv_column_pkg::OP_INV_SUB_WORD) ||
                   (op == inv_column_pkg::OP_INV_MIX_COLUMN);

    // an erroring access must leave every register untouched
    always_comb begin
        pslverr = 1'b0;
        if (access) begin
            case (paddr)
                inv_column_pkg::REG_CTRL:   pslverr = pwrite && (busy_q || !op_ok);
                inv_column_pkg::REG_DATA:   pslverr = pwrite && busy_q;
                inv_column_pkg::REG_RESULT: pslverr = pwrite;
                inv_column_pkg::REG_STATUS: pslverr = pwrite;
                default:                    pslverr = 1'b1;
            endcase
        end
    end

    assign start   = access && pwrite && !pslverr && (paddr == inv_column_pkg::REG_CTRL);
    assign data_wr = access && pwrite && !pslverr && (paddr == inv_column_pkg::REG_DATA);

    assign rsp_valid = sub_rsp.valid || mix_rsp.valid;

    always_comb begin
        status = '0;
        status[inv_column_pkg::STATUS_BUSY_BIT] = busy_q;
        status[inv_column_pkg::STATUS_DONE_BIT] = done_q;
    end

    always_comb begin
        case (paddr)
            inv_column_pkg::REG_DATA:   prdata = data_q;
            inv_column_pkg::REG_RESULT: prdata = result_q;
            inv_column_pkg::REG_STATUS: prdata = status;
            default:                    prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_q      <= '0;
            result_q    <= '0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            sub_valid_q <= 1'b0;
            mix_valid_q <= 1'b0;
        end else begin
            sub_valid_q <= start && (op == inv_column_pkg::OP_INV_SUB_WORD);
            mix_valid_q <= start && (op == inv_column_pkg::OP_INV_MIX_COLUMN);
            if (data_wr) begin
                data_q <= pwdata;
            end
            if (start) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end
            if (rsp_valid) begin
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
                result_q <= sub_rsp.valid ? sub_rsp.data : mix_rsp.data;
            end
        end
    end

    // DATA is locked while busy, so the operand stays stable for the datapaths
    assign sub_req = '{valid: sub_valid_q, data: data_q};
    assign mix_req = '{valid: mix_valid_q, data: data_q};

    a_single_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        !(sub_rsp.valid && mix_rsp.valid))
        else $error("both datapaths responded in the same cycle");

    a_rsp_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> busy_q)
        else $error("datapath response with no operation in flight");

endmodule

// ==== src/inv_sub_word.sv ====
module inv_sub_word (
    input  logic                     clk,
    input  logic                     arst_n,
    input  inv_column_pkg::col_req_t req,
    output inv_column_pkg::col_rsp_t rsp
);

    logic                    valid_q;
    inv_column_pkg::column_t data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    // one table lookup per byte, all four in parallel
    always_ff @(posedge clk) begin
        if (req.valid) begin
            for (int k = 0; k < 4; k++) begin
                data_q[k] <= inv_column_pkg::INV_SBOX[req.data[k]];
            end
        end
    end

    assign rsp = '{valid: valid_q, data: data_q};

    a_rsp_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
        req.valid |=> !req.valid)
        else $error("inverse sub word request held longer than one cycle");

endmodule

// ==== src/inv_mix_column.sv ====
module inv_mix_column (
    input  logic                     clk,
    input  logic                     arst_n,
    input  inv_column_pkg::col_req_t req,
    output inv_column_pkg::col_rsp_t rsp
);

    // stage 1 holds s and 2s, stage 2 adds 4s
    inv_column_pkg::column_t s1;
    inv_column_pkg::column_t d1;
    inv_column_pkg::column_t s2;
    inv_column_pkg::column_t d2;
    inv_column_pkg::column_t q2;
    logic                    v1;
    logic                    v2;
    logic                    v3;

    inv_column_pkg::column_t e8;
    inv_column_pkg::column_t m09;
    inv_column_pkg::column_t m0b;
    inv_column_pkg::column_t m0d;
    inv_column_pkg::column_t m0e;
    inv_column_pkg::column_t mixed;
    inv_column_pkg::column_t sum_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= req.valid;
            v2 <= v1;
            v3 <= v2;
        end
    end

    // s travels with its doublings so every term of a byte belongs to the same item
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            s1[k] <= req.data[k];
            d1[k] <= inv_column_pkg::xtime(req.data[k]);
            s2[k] <= s1[k];
            d2[k] <= d1[k];
            q2[k] <= inv_column_pkg::xtime(d1[k]);
        end
        sum_q <= mixed;
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            e8[k]  = inv_column_pkg::xtime(q2[k]);
            m09[k] = e8[k] ^ s2[k];
            m0b[k] = e8[k] ^ d2[k] ^ s2[k];
            m0d[k] = e8[k] ^ q2[k] ^ s2[k];
            m0e[k] = e8[k] ^ q2[k] ^ d2[k];
        end
    end

    // positions count down from row 0, so (row_in - row_out) mod 4 is (p - q) mod 4
    always_comb begin
        mixed = '0;
        for (int p = 0; p < 4; p++) begin
            for (int q = 0; q < 4; q++) begin
                case (2'(p - q))
                    2'd0:    mixed[p] = mixed[p] ^ m0e[q];
                    2'd1:    mixed[p] = mixed[p] ^ m0b[q];
                    2'd2:    mixed[p] = mixed[p] ^ m0d[q];
                    default: mixed[p] = mixed[p] ^ m09[q];
                endcase
            end
        end
    end

    assign rsp = '{valid: v3, data: sum_q};

    // the four coefficients XOR to 01, so a column of equal bytes comes back unchanged
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.valid && ($past(req.data, 3) == {4{$past(req.data[0], 3)}})
        |-> rsp.data == $past(req.data, 3))
        else $error("inverse mix column changed a column of equal bytes");

endmodule

// ==== src/inv_column_unit.sv ====
module inv_column_unit (
    input  logic                      clk,
    input  logic                      arst_n,
    input  inv_column_pkg::apb_addr_t paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);

    inv_column_pkg::col_req_t sub_req;
    inv_column_pkg::col_req_t mix_req;
    inv_column_pkg::col_rsp_t sub_rsp;
    inv_column_pkg::col_rsp_t mix_rsp;

    inv_column_apb i_apb (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .sub_req (sub_req),
        .mix_req (mix_req),
        .sub_rsp (sub_rsp),
        .mix_rsp (mix_rsp)
    );

    inv_sub_word i_sub_word (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (sub_req),
        .rsp    (sub_rsp)
    );

    inv_mix_column i_mix_column (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mix_req),
        .rsp    (mix_rsp)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // reset lets go just after an edge, like the rest of the stimulus
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 arst_n = 1'b1;
    end

endmodule

// ==== tests/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int          DRIVE_DELAY = 10;
localparam int          WAIT_LIMIT  = 40;
localparam logic [31:0] LFSR_SEED   = 32'h2d2b;
localparam logic [31:0] SUB_IN_A    = 32'h0063ff01;
localparam logic [31:0] SUB_OUT_A   = 32'h52007d09;
localparam logic [31:0] SUB_IN_B    = 32'h52097d6a;
localparam logic [31:0] SUB_OUT_B   = 32'h48401358;
localparam logic [31:0] MIX_IN      = 32'h8e4da1bc;
localparam logic [31:0] MIX_OUT     = 32'hdb135345;

logic [31:0] lfsr_state;

// taps at 32, 22, 2 and 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic random_column(output inv_column_pkg::column_t col);
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < 32; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        word = {word[30:0], lfsr_state[0]};
    end
    col = word;
endtask

// shift and add, doubling the partial term once per coefficient bit
function automatic inv_column_pkg::byte_t gf_mul(input inv_column_pkg::byte_t a,
                                                 input inv_column_pkg::byte_t coef);
    inv_column_pkg::byte_t acc;
    inv_column_pkg::byte_t term;
    acc  = '0;
    term = a;
    for (int i = 0; i < 8; i++) begin
        if (coef[i]) begin
            acc = acc ^ term;
        end
        term = {term[6:0], 1'b0} ^ (term[7] ? 8'h1b : 8'h00);
    end
    return acc;
endfunction

// row r of the output takes input row k with the coefficient picked by (k - r) mod 4
function automatic inv_column_pkg::column_t inv_mix_model(input inv_column_pkg::column_t col);
    inv_column_pkg::byte_t   coefs [0:3];
    inv_column_pkg::column_t res;
    coefs = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
    res   = '0;
    for (int r = 0; r < 4; r++) begin
        for (int k = 0; k < 4; k++) begin
            res[3 - r] = res[3 - r] ^ gf_mul(col[3 - k], coefs[(k - r + 4) % 4]);
        end
    end
    return res;
endfunction

task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_column(input string name, input inv_column_pkg::column_t actual,
                            input inv_column_pkg::column_t expected);
    if (actual !== expected) begin
        $display("FAIL time %0t %s: got %h, expected %h", $time, name, actual, expected);
        stop_run();
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("FAIL time %0t %s: got %b, expected %b", $time, name, actual, expected);
        stop_run();
    end
endtask

// both transfers start and end a short delay after a rising edge, back to back
task automatic write_reg(input inv_column_pkg::apb_addr_t addr, input logic [31:0] wdata,
                         output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DELAY penable = 1'b1;
    @(negedge clk);
    err = pslverr;
    check_bit("pready", pready, 1'b1);
    @(posedge clk);
    #DRIVE_DELAY;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic read_reg(input inv_column_pkg::apb_addr_t addr, output logic [31:0] rdata,
                        output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #DRIVE_DELAY penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    check_bit("pready", pready, 1'b1);
    @(posedge clk);
    #DRIVE_DELAY;
    psel    = 1'b0;
    penable = 1'b0;
endtask

`endif

// ==== tests/tb_inv_column_unit.sv ====
module tb_inv_column_unit;

    logic                      clk;
    logic                      arst_n;
    inv_column_pkg::apb_addr_t paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;

    `include "tb_checks.svh"

    tb_clock_gen i_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    inv_column_unit i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (arst_n !== 1'b1) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("reset was never released");
                stop_run();
            end
            cycles++;
            @(posedge clk);
        end
        #DRIVE_DELAY;
    endtask

    task automatic wait_done();
        logic [31:0] status;
        logic        err;
        int          polls;
        polls = 0;
        read_reg(inv_column_pkg::REG_STATUS, status, err);
        while (status[inv_column_pkg::STATUS_DONE_BIT] !== 1'b1) begin
            if (polls >= WAIT_LIMIT) begin
                $display("operation never finished, done stayed low in STATUS");
                stop_run();
            end
            polls++;
            read_reg(inv_column_pkg::REG_STATUS, status, err);
        end
    endtask

    task automatic run_op(input inv_column_pkg::op_t op, input logic [31:0] operand,
                          output inv_column_pkg::column_t result);
        logic [31:0] rdata;
        logic        err;
        write_reg(inv_column_pkg::REG_DATA, operand, err);
        check_bit("pslverr on DATA write", err, 1'b0);
        write_reg(inv_column_pkg::REG_CTRL, 32'(op), err);
        check_bit("pslverr on CTRL write", err, 1'b0);
        wait_done();
        read_reg(inv_column_pkg::REG_RESULT, rdata, err);
        result = rdata;
    endtask

    task automatic check_regs(input logic [31:0] data_exp, input logic [31:0] result_exp);
        logic [31:0] rdata;
        logic        err;
        read_reg(inv_column_pkg::REG_DATA, rdata, err);
        check_bit("pslverr on DATA read", err, 1'b0);
        check_column("DATA", rdata, data_exp);
        read_reg(inv_column_pkg::REG_RESULT, rdata, err);
        check_bit("pslverr on RESULT read", err, 1'b0);
        check_column("RESULT", rdata, result_exp);
        read_reg(inv_column_pkg::REG_STATUS, rdata, err);
        check_bit("STATUS.busy", rdata[inv_column_pkg::STATUS_BUSY_BIT], 1'b0);
    endtask

    task automatic test_reset_values();
        logic [31:0] rdata;
        logic        err;
        read_reg(inv_column_pkg::REG_STATUS, rdata, err);
        check_bit("pslverr", err, 1'b0);
        check_bit("STATUS.busy", rdata[inv_column_pkg::STATUS_BUSY_BIT], 1'b0);
        check_bit("STATUS.done", rdata[inv_column_pkg::STATUS_DONE_BIT], 1'b0);
        check_regs(32'h0, 32'h0);
    endtask

    task automatic test_sub_vectors();
        inv_column_pkg::column_t result;
        run_op(inv_column_pkg::OP_INV_SUB_WORD, SUB_IN_A, result);
        check_column("RESULT", result, SUB_OUT_A);
        run_op(inv_column_pkg::OP_INV_SUB_WORD, SUB_IN_B, result);
        check_column("RESULT", result, SUB_OUT_B);
    endtask

    // a bijection maps the 256 inputs onto 256 different outputs
    task automatic test_sub_bijection();
        inv_column_pkg::column_t result;
        bit                      seen [0:255];
        seen = '{default: 1'b0};
        for (int w = 0; w < 64; w++) begin
            run_op(inv_column_pkg::OP_INV_SUB_WORD,
                   {8'(4 * w), 8'(4 * w + 1), 8'(4 * w + 2), 8'(4 * w + 3)}, result);
            for (int k = 0; k < 4; k++) begin
                check_bit("repeated byte in RESULT", seen[result[k]], 1'b0);
                seen[result[k]] = 1'b1;
            end
        end
    endtask

    task automatic test_error_cases();
        inv_column_pkg::column_t result;
        logic                    err;
        run_op(inv_column_pkg::OP_INV_SUB_WORD, SUB_IN_A, result);
        write_reg(4'd2, 32'hffff_ffff, err);
        check_bit("pslverr on unmapped write", err, 1'b1);
        check_regs(SUB_IN_A, SUB_OUT_A);
        write_reg(inv_column_pkg::REG_CTRL, 32'd0, err);
        check_bit("pslverr on opcode 0", err, 1'b1);
        write_reg(inv_column_pkg::REG_CTRL, 32'd3, err);
        check_bit("pslverr on opcode 3", err, 1'b1);
        check_regs(SUB_IN_A, SUB_OUT_A);
        write_reg(inv_column_pkg::REG_RESULT, 32'h1234_5678, err);
        check_bit("pslverr on RESULT write", err, 1'b1);
        check_regs(SUB_IN_A, SUB_OUT_A);
        // the DATA write lands in the cycle right after the start, while busy
        write_reg(inv_column_pkg::REG_CTRL, 32'(inv_column_pkg::OP_INV_SUB_WORD), err);
        check_bit("pslverr on CTRL write", err, 1'b0);
        write_reg(inv_column_pkg::REG_DATA, 32'hdead_beef, err);
        check_bit("pslverr on DATA write while busy", err, 1'b1);
        wait_done();
        check_regs(SUB_IN_A, SUB_OUT_A);
    endtask

    task automatic test_mix_column();
        inv_column_pkg::column_t operand;
        inv_column_pkg::column_t result;
        run_op(inv_column_pkg::OP_INV_MIX_COLUMN, MIX_IN, result);
        check_column("RESULT", result, MIX_OUT);
        for (int n = 0; n < 16; n++) begin
            random_column(operand);
            run_op(inv_column_pkg::OP_INV_MIX_COLUMN, operand, result);
            check_column("RESULT", result, inv_mix_model(operand));
        end
    endtask

    initial begin
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        lfsr_state = LFSR_SEED;
        wait_reset_release();
        test_reset_values();
        test_sub_vectors();
        test_sub_bijection();
        test_error_cases();
        test_mix_column();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== inv_column_unit.f ====
+incdir+tests
src/inv_column_pkg.sv
src/inv_column_apb.sv
src/inv_sub_word.sv
src/inv_mix_column.sv
src/inv_column_unit.sv
tests/tb_clock_gen.sv
tests/tb_inv_column_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f inv_column_unit.f --top-module tb_inv_column_unit -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
